//--- common/pong_pkg.sv
package pong_pkg;

	// display geometry
	parameter int SCREEN_W = 320;
	parameter int SCREEN_H = 240;
	parameter int Y_MARGIN = 20;
	parameter int Y_MIN = Y_MARGIN;

	// object sizes
	parameter int PADDLE_W = 5;
	parameter int PADDLE_H = 40;
	parameter int BALL_W = 4;
	parameter int BALL_H = 4;

	// fixed paddle columns and vertical travel
	parameter int PADDLE_L_X = 2;
	parameter int PADDLE_R_X = SCREEN_W - PADDLE_W;
	parameter int PADDLE_MAX_Y = SCREEN_H - 1 - PADDLE_H - Y_MARGIN;
	parameter int PADDLE_HOME_Y = 100;

	// ball origin treated as already on screen after reset
	parameter int BALL_HOME_X = 158;
	parameter int BALL_HOME_Y = 118;

	parameter int PADDLE_COLOUR = 7;
	parameter int BALL_COLOUR = 2;
	parameter int BLACK = 0;

	typedef logic [8:0] x_coord_t;
	typedef logic [7:0] y_coord_t;
	typedef logic [2:0] colour_t;

	// each box has an issue state and a wait state
	typedef enum logic [3:0] {
		IDLE,
		P1_CLEAR,
		P1_CLEAR_WAIT,
		P1_DRAW,
		P1_DRAW_WAIT,
		P2_CLEAR,
		P2_CLEAR_WAIT,
		P2_DRAW,
		P2_DRAW_WAIT,
		BALL_CLEAR,
		BALL_CLEAR_WAIT,
		BALL_DRAW,
		BALL_DRAW_WAIT
	} draw_step_e;

endpackage

//--- design/frame_timer.sv
`timescale 1ns/100ps

module frame_timer #(
	parameter int FRAME_CLOCKS = 833333
) (
	input  logic clk,
	input  logic resetn,
	output logic frame_tick
);

	localparam int CW = $clog2(FRAME_CLOCKS);

	logic [CW-1:0] count;

	// down counter, one strobe per reload
	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= CW'(FRAME_CLOCKS - 1);
			frame_tick <= 1'b0;
		end else begin
			if (count == '0) begin
				count <= CW'(FRAME_CLOCKS - 1);
			end else begin
				count <= count - 1'b1;
			end
			// registered so the first strobe lands FRAME_CLOCKS cycles out
			frame_tick <= (count == '0);
		end
	end

endmodule

//--- design/paddle_tracker.sv
`timescale 1ns/100ps

module paddle_tracker #(
	parameter int PADDLE_STEP = 3
) (
	input  logic clk,
	input  logic resetn,
	input  logic frame_tick,
	input  logic up,
	input  logic down,
	output pong_pkg::y_coord_t paddle_y
);

	import pong_pkg::*;

	logic move_up;
	logic move_down;

	// both buttons at once cancel out
	assign move_up = up && !down;
	assign move_down = down && !up;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			paddle_y <= y_coord_t'(PADDLE_HOME_Y);
		end else if (frame_tick) begin
			if (move_up) begin
				// saturate at the top of the playfield
				if (int'(paddle_y) < Y_MIN + PADDLE_STEP) begin
					paddle_y <= y_coord_t'(Y_MIN);
				end else begin
					paddle_y <= paddle_y - y_coord_t'(PADDLE_STEP);
				end
			end else if (move_down) begin
				// saturate at the lowest allowed top row
				if (int'(paddle_y) + PADDLE_STEP > PADDLE_MAX_Y) begin
					paddle_y <= y_coord_t'(PADDLE_MAX_Y);
				end else begin
					paddle_y <= paddle_y + y_coord_t'(PADDLE_STEP);
				end
			end
		end
	end

endmodule

//--- render/box_raster.sv
`timescale 1ns/100ps

module box_raster (
	input  logic clk,
	input  logic resetn,
	input  logic start,
	input  pong_pkg::x_coord_t org_x,
	input  pong_pkg::y_coord_t org_y,
	input  pong_pkg::x_coord_t box_w,
	input  pong_pkg::y_coord_t box_h,
	output pong_pkg::x_coord_t pix_x,
	output pong_pkg::y_coord_t pix_y,
	output logic plot,
	output logic done
);

	import pong_pkg::*;

	// offsets inside the box
	x_coord_t col;
	y_coord_t row;
	logic busy;
	logic last_pix;

	assign last_pix = (col == box_w - 1'b1) && (row == box_h - 1'b1);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			done <= 1'b0;
			col <= '0;
			row <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				col <= '0;
				row <= '0;
			end else if (busy) begin
				if (last_pix) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else if (col == box_w - 1'b1) begin
					// row finished, wrap to the left edge
					col <= '0;
					row <= row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// one pixel per cycle while walking
	assign plot = busy;
	assign pix_x = org_x + col;
	assign pix_y = org_y + row;

endmodule

//--- render/draw_sequencer.sv
`timescale 1ns/100ps

module draw_sequencer (
	input  logic clk,
	input  logic resetn,
	input  logic frame_tick,
	input  pong_pkg::y_coord_t paddle_l_y,
	input  pong_pkg::y_coord_t paddle_r_y,
	input  pong_pkg::x_coord_t ball_x,
	input  pong_pkg::y_coord_t ball_y,
	input  logic raster_done,
	output logic raster_start,
	output pong_pkg::x_coord_t org_x,
	output pong_pkg::y_coord_t org_y,
	output pong_pkg::x_coord_t box_w,
	output pong_pkg::y_coord_t box_h,
	output pong_pkg::colour_t pix_colour
);

	import pong_pkg::*;

	draw_step_e step;
	draw_step_e step_next;

	// origins drawn in the previous frame
	y_coord_t prev_l_y;
	y_coord_t prev_r_y;
	x_coord_t prev_ball_x;
	y_coord_t prev_ball_y;

	// ball position captured at the frame strobe
	x_coord_t ball_x_q;
	y_coord_t ball_y_q;

	always_comb begin
		step_next = step;
		case (step)
			IDLE:            if (frame_tick) step_next = P1_CLEAR;
			P1_CLEAR:        step_next = P1_CLEAR_WAIT;
			P1_CLEAR_WAIT:   if (raster_done) step_next = P1_DRAW;
			P1_DRAW:         step_next = P1_DRAW_WAIT;
			P1_DRAW_WAIT:    if (raster_done) step_next = P2_CLEAR;
			P2_CLEAR:        step_next = P2_CLEAR_WAIT;
			P2_CLEAR_WAIT:   if (raster_done) step_next = P2_DRAW;
			P2_DRAW:         step_next = P2_DRAW_WAIT;
			P2_DRAW_WAIT:    if (raster_done) step_next = BALL_CLEAR;
			BALL_CLEAR:      step_next = BALL_CLEAR_WAIT;
			BALL_CLEAR_WAIT: if (raster_done) step_next = BALL_DRAW;
			BALL_DRAW:       step_next = BALL_DRAW_WAIT;
			BALL_DRAW_WAIT:  if (raster_done) step_next = IDLE;
			default:         step_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			step <= IDLE;
		end else begin
			step <= step_next;
		end
	end

	// strobe ignored unless idle
	always_ff @(posedge clk) begin
		if (step == IDLE && frame_tick) begin
			ball_x_q <= ball_x;
			ball_y_q <= ball_y;
		end
	end

	// record each draw origin once its box is finished
	always_ff @(posedge clk) begin
		if (!resetn) begin
			prev_l_y <= y_coord_t'(PADDLE_HOME_Y);
			prev_r_y <= y_coord_t'(PADDLE_HOME_Y);
			prev_ball_x <= x_coord_t'(BALL_HOME_X);
			prev_ball_y <= y_coord_t'(BALL_HOME_Y);
		end else if (raster_done) begin
			case (step)
				P1_DRAW_WAIT: prev_l_y <= paddle_l_y;
				P2_DRAW_WAIT: prev_r_y <= paddle_r_y;
				BALL_DRAW_WAIT: begin
					prev_ball_x <= ball_x_q;
					prev_ball_y <= ball_y_q;
				end
				default: ;
			endcase
		end
	end

	assign raster_start = (step == P1_CLEAR) || (step == P1_DRAW) ||
		(step == P2_CLEAR) || (step == P2_DRAW) ||
		(step == BALL_CLEAR) || (step == BALL_DRAW);

	// box and colour follow the step for its whole duration
	always_comb begin
		org_x = '0;
		org_y = '0;
		box_w = x_coord_t'(PADDLE_W);
		box_h = y_coord_t'(PADDLE_H);
		pix_colour = colour_t'(BLACK);
		case (step)
			P1_CLEAR, P1_CLEAR_WAIT: begin
				org_x = x_coord_t'(PADDLE_L_X);
				org_y = prev_l_y;
			end
			P1_DRAW, P1_DRAW_WAIT: begin
				org_x = x_coord_t'(PADDLE_L_X);
				org_y = paddle_l_y;
				pix_colour = colour_t'(PADDLE_COLOUR);
			end
			P2_CLEAR, P2_CLEAR_WAIT: begin
				org_x = x_coord_t'(PADDLE_R_X);
				org_y = prev_r_y;
			end
			P2_DRAW, P2_DRAW_WAIT: begin
				org_x = x_coord_t'(PADDLE_R_X);
				org_y = paddle_r_y;
				pix_colour = colour_t'(PADDLE_COLOUR);
			end
			BALL_CLEAR, BALL_CLEAR_WAIT: begin
				org_x = prev_ball_x;
				org_y = prev_ball_y;
				box_w = x_coord_t'(BALL_W);
				box_h = y_coord_t'(BALL_H);
			end
			BALL_DRAW, BALL_DRAW_WAIT: begin
				org_x = ball_x_q;
				org_y = ball_y_q;
				box_w = x_coord_t'(BALL_W);
				box_h = y_coord_t'(BALL_H);
				pix_colour = colour_t'(BALL_COLOUR);
			end
			default: ;
		endcase
	end

endmodule

//--- design/pong_render_top.sv
`timescale 1ns/100ps

module pong_render_top #(
	parameter int FRAME_CLOCKS = 833333,
	parameter int PADDLE_STEP = 3
) (
	input  logic clk,
	input  logic resetn,
	input  logic up_l,
	input  logic down_l,
	input  logic up_r,
	input  logic down_r,
	input  pong_pkg::x_coord_t ball_x,
	input  pong_pkg::y_coord_t ball_y,
	output pong_pkg::x_coord_t pix_x,
	output pong_pkg::y_coord_t pix_y,
	output pong_pkg::colour_t pix_colour,
	output logic plot
);

	import pong_pkg::*;

	logic frame_tick;
	y_coord_t paddle_l_y;
	y_coord_t paddle_r_y;

	// shared rasterizer request from the sequencer
	logic raster_start;
	logic raster_done;
	x_coord_t org_x;
	y_coord_t org_y;
	x_coord_t box_w;
	y_coord_t box_h;

	frame_timer #(
		.FRAME_CLOCKS(FRAME_CLOCKS)
	) u_frame_timer (
		.clk        (clk),
		.resetn     (resetn),
		.frame_tick (frame_tick)
	);

	paddle_tracker #(
		.PADDLE_STEP(PADDLE_STEP)
	) u_paddle_l (
		.clk        (clk),
		.resetn     (resetn),
		.frame_tick (frame_tick),
		.up         (up_l),
		.down       (down_l),
		.paddle_y   (paddle_l_y)
	);

	paddle_tracker #(
		.PADDLE_STEP(PADDLE_STEP)
	) u_paddle_r (
		.clk        (clk),
		.resetn     (resetn),
		.frame_tick (frame_tick),
		.up         (up_r),
		.down       (down_r),
		.paddle_y   (paddle_r_y)
	);

	draw_sequencer u_draw_sequencer (
		.clk          (clk),
		.resetn       (resetn),
		.frame_tick   (frame_tick),
		.paddle_l_y   (paddle_l_y),
		.paddle_r_y   (paddle_r_y),
		.ball_x       (ball_x),
		.ball_y       (ball_y),
		.raster_done  (raster_done),
		.raster_start (raster_start),
		.org_x        (org_x),
		.org_y        (org_y),
		.box_w        (box_w),
		.box_h        (box_h),
		.pix_colour   (pix_colour)
	);

	box_raster u_box_raster (
		.clk    (clk),
		.resetn (resetn),
		.start  (raster_start),
		.org_x  (org_x),
		.org_y  (org_y),
		.box_w  (box_w),
		.box_h  (box_h),
		.pix_x  (pix_x),
		.pix_y  (pix_y),
		.plot   (plot),
		.done   (raster_done)
	);

endmodule

//--- dv/pong_sva.sv
`timescale 1ns/100ps

module pong_sva (
	input logic clk,
	input logic resetn,
	input logic start,
	input logic plot,
	input logic done,
	input pong_pkg::x_coord_t pix_x,
	input pong_pkg::y_coord_t pix_y
);

	import pong_pkg::*;

	// the sequencer issues a new box only once the walker is idle
	start_while_plotting: assert property (@(posedge clk) disable iff (!resetn)
		!(start && plot))
		else $error("raster start issued while a box is plotting");

	done_single_cycle: assert property (@(posedge clk) disable iff (!resetn)
		done |=> !done)
		else $error("raster done held for more than one cycle");

	pixel_on_screen: assert property (@(posedge clk) disable iff (!resetn)
		plot |-> (int'(pix_x) < SCREEN_W) && (int'(pix_y) < SCREEN_H))
		else $error("plotted pixel outside the screen");

endmodule

bind box_raster pong_sva u_sva (
	.clk    (clk),
	.resetn (resetn),
	.start  (start),
	.plot   (plot),
	.done   (done),
	.pix_x  (pix_x),
	.pix_y  (pix_y)
);

//--- dv/pong_tb.sv
`timescale 1ns/100ps

module pong_tb;

	import pong_pkg::*;

	localparam int FRAME_CLOCKS = 2000;
	localparam int PADDLE_STEP = 3;

	logic clk;
	logic resetn;
	logic up_l;
	logic down_l;
	logic up_r;
	logic down_r;
	x_coord_t ball_x;
	y_coord_t ball_y;
	x_coord_t pix_x;
	y_coord_t pix_y;
	colour_t pix_colour;
	logic plot;

	// reference model: expected paddle rows and last drawn ball origin
	int exp_l_y;
	int exp_r_y;
	int drawn_bx;
	int drawn_by;

	// pixels of the most recent box
	x_coord_t got_x[$];
	y_coord_t got_y[$];
	colour_t got_c[$];

	pong_render_top #(
		.FRAME_CLOCKS(FRAME_CLOCKS),
		.PADDLE_STEP(PADDLE_STEP)
	) u_dut (
		.clk        (clk),
		.resetn     (resetn),
		.up_l       (up_l),
		.down_l     (down_l),
		.up_r       (up_r),
		.down_r     (down_r),
		.ball_x     (ball_x),
		.ball_y     (ball_y),
		.pix_x      (pix_x),
		.pix_y      (pix_y),
		.pix_colour (pix_colour),
		.plot       (plot)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_x(input string name, input x_coord_t exp, input x_coord_t act);
		if (exp !== act) begin
			stop_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act));
		end
	endtask

	task automatic check_y(input string name, input y_coord_t exp, input y_coord_t act);
		if (exp !== act) begin
			stop_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act));
		end
	endtask

	task automatic check_colour(input string name, input colour_t exp, input colour_t act);
		if (exp !== act) begin
			stop_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			stop_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act));
		end
	endtask

	// one frame of paddle movement, saturating at the playfield limits
	function automatic int next_row(input int row, input logic up, input logic dn);
		if (up && !dn) begin
			return (row - PADDLE_STEP < Y_MIN) ? Y_MIN : row - PADDLE_STEP;
		end
		if (dn && !up) begin
			return (row + PADDLE_STEP > PADDLE_MAX_Y) ? PADDLE_MAX_Y : row + PADDLE_STEP;
		end
		return row;
	endfunction

	task automatic collect_box(input int timeout);
		int waited;
		waited = 0;
		got_x.delete();
		got_y.delete();
		got_c.delete();
		@(negedge clk);
		while (!plot) begin
			if (waited == timeout) begin
				stop_run("timed out waiting for a box to start plotting");
			end
			waited++;
			@(negedge clk);
		end
		while (plot) begin
			if (got_x.size() > 4096) begin
				stop_run("plot stayed high far longer than any box");
			end
			got_x.push_back(pix_x);
			got_y.push_back(pix_y);
			got_c.push_back(pix_colour);
			@(negedge clk);
		end
	endtask

	// row-major walk from the origin, x fastest
	task automatic check_box(input string name, input int ox, input int oy, input int w,
		input int h, input colour_t c);
		check_count({name, " pixel count"}, w * h, got_x.size());
		for (int i = 0; i < w * h; i++) begin
			check_x($sformatf("%s pix_x[%0d]", name, i), x_coord_t'(ox + i % w), got_x[i]);
			check_y($sformatf("%s pix_y[%0d]", name, i), y_coord_t'(oy + i / w), got_y[i]);
			check_colour($sformatf("%s pix_colour[%0d]", name, i), c, got_c[i]);
		end
	endtask

	task automatic run_frame(input logic ul, input logic dl, input logic ur, input logic dr,
		input int bx, input int by, input bit scramble);
		int old_l;
		int old_r;
		@(negedge clk);
		up_l = ul;
		down_l = dl;
		up_r = ur;
		down_r = dr;
		ball_x = x_coord_t'(bx);
		ball_y = y_coord_t'(by);
		old_l = exp_l_y;
		old_r = exp_r_y;
		exp_l_y = next_row(exp_l_y, ul, dl);
		exp_r_y = next_row(exp_r_y, ur, dr);
		collect_box(3 * FRAME_CLOCKS);
		check_box("left clear", PADDLE_L_X, old_l, PADDLE_W, PADDLE_H, BLACK);
		// move the ball inputs while the frame is drawing
		if (scramble) begin
			ball_x = x_coord_t'($urandom_range(PADDLE_R_X - BALL_W, PADDLE_L_X + PADDLE_W));
			ball_y = y_coord_t'($urandom_range(SCREEN_H - Y_MARGIN - BALL_H, Y_MIN));
		end
		collect_box(16);
		check_box("left draw", PADDLE_L_X, exp_l_y, PADDLE_W, PADDLE_H, PADDLE_COLOUR);
		collect_box(16);
		check_box("right clear", PADDLE_R_X, old_r, PADDLE_W, PADDLE_H, BLACK);
		collect_box(16);
		check_box("right draw", PADDLE_R_X, exp_r_y, PADDLE_W, PADDLE_H, PADDLE_COLOUR);
		collect_box(16);
		check_box("ball clear", drawn_bx, drawn_by, BALL_W, BALL_H, BLACK);
		collect_box(16);
		check_box("ball draw", bx, by, BALL_W, BALL_H, BALL_COLOUR);
		drawn_bx = bx;
		drawn_by = by;
	endtask

	task automatic test_first_frame();
		for (int n = 0; n < FRAME_CLOCKS - 4; n++) begin
			@(negedge clk);
			if (plot) begin
				stop_run("plot rose before the first frame strobe");
			end
		end
		run_frame(1'b0, 1'b0, 1'b0, 1'b0, 60, 50, 1'b0);
	endtask

	task automatic test_paddle_clamp();
		repeat (40) run_frame(1'b1, 1'b0, 1'b0, 1'b1, 60, 50, 1'b0);
		check_y("left paddle top rest", y_coord_t'(Y_MIN), y_coord_t'(exp_l_y));
		check_y("right paddle bottom rest", y_coord_t'(PADDLE_MAX_Y), y_coord_t'(exp_r_y));
		repeat (60) run_frame(1'b0, 1'b1, 1'b1, 1'b0, 60, 50, 1'b0);
		check_y("left paddle bottom rest", y_coord_t'(PADDLE_MAX_Y), y_coord_t'(exp_l_y));
		check_y("right paddle top rest", y_coord_t'(Y_MIN), y_coord_t'(exp_r_y));
	endtask

	task automatic test_still_buttons();
		repeat (3) run_frame(1'b1, 1'b1, 1'b1, 1'b1, 60, 50, 1'b0);
		repeat (3) run_frame(1'b0, 1'b0, 1'b0, 1'b0, 60, 50, 1'b0);
	endtask

	task automatic test_ball_sampling();
		int bx;
		int by;
		repeat (8) begin
			bx = $urandom_range(PADDLE_R_X - BALL_W, PADDLE_L_X + PADDLE_W);
			by = $urandom_range(SCREEN_H - Y_MARGIN - BALL_H, Y_MIN);
			run_frame(1'b0, 1'b0, 1'b0, 1'b0, bx, by, 1'b1);
		end
	endtask

	initial begin
		void'($urandom(69));
		resetn = 1'b0;
		up_l = 1'b0;
		down_l = 1'b0;
		up_r = 1'b0;
		down_r = 1'b0;
		ball_x = x_coord_t'(60);
		ball_y = y_coord_t'(50);
		exp_l_y = PADDLE_HOME_Y;
		exp_r_y = PADDLE_HOME_Y;
		drawn_bx = BALL_HOME_X;
		drawn_by = BALL_HOME_Y;
		repeat (16) @(negedge clk);
		resetn = 1'b1;
		test_first_frame();
		test_paddle_clamp();
		test_still_buttons();
		test_ball_sampling();
		$display("Test OK");
		$finish;
	end

endmodule

//--- pong_render.f
common/pong_pkg.sv
design/frame_timer.sv
design/paddle_tracker.sv
render/box_raster.sv
render/draw_sequencer.sv
design/pong_render_top.sv
dv/pong_sva.sv
dv/pong_tb.sv
